//--- alu_settings.svh
// ALU build settings
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Data word width
`define ALU_WIDTH 32

// Opcode field width
`define ALU_OP_WIDTH 6

// Iterations of the multiplier and the divider
`define ALU_MULDIV_CYCLES 32

`endif

//--- alu_types_pkg.sv
// ALU data and opcode types
`default_nettype none
`include "alu_settings.svh"

package alu_types_pkg;

	typedef logic [`ALU_WIDTH-1:0] word_t;
	typedef logic [$clog2(`ALU_WIDTH)-1:0] shamt_t; // Shift amount taken from operand_a

	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		SLL    = 6'b000000,
		SRL    = 6'b000010,
		SRA    = 6'b000011,
		SLLV   = 6'b000100,
		SRLV   = 6'b000110,
		SRAV   = 6'b000111,
		JR     = 6'b001000,
		JALR   = 6'b001001,
		MFHI   = 6'b010000,
		MTHI   = 6'b010001,
		MFLO   = 6'b010010,
		MTLO   = 6'b010011,
		MULT   = 6'b011000,
		MULTU  = 6'b011001,
		DIV    = 6'b011010,
		DIVU   = 6'b011011,
		ADD    = 6'b100000,
		ADDU   = 6'b100001,
		SUB    = 6'b100010,
		SUBU   = 6'b100011,
		AND    = 6'b100100,
		OR     = 6'b100101,
		XOR    = 6'b100110,
		NOR    = 6'b100111,
		SLT    = 6'b101010,
		SLTU   = 6'b101011,
		LUI    = 6'b101100,
		PASS_A = 6'b111110, // Operand a flows through unchanged
		PASS_B = 6'b111111  // Operand b flows through unchanged
	} alu_op_e;

endpackage

`default_nettype wire

//--- muldiv_pkg.sv
// Long operation control types
`default_nettype none

package muldiv_pkg;

	// Sequencer state shared by multiplier and divider
	typedef enum logic {
		IDLE = 1'b0,
		RUN  = 1'b1
	} muldiv_state_e;

	// Which writer owns the next HI/LO update
	typedef enum logic [1:0] {
		NONE = 2'b00,
		MULT = 2'b01,
		DIV  = 2'b10,
		MOVE = 2'b11
	} hilo_src_e;

endpackage

`default_nettype wire

//--- muldiv_if.sv
// Long operation bus
`timescale 1ns/1ps
`default_nettype none

interface muldiv_if;

	logic                 start;     // One-cycle pulse while busy is low
	logic                 is_signed;
	alu_types_pkg::word_t operand_a;
	alu_types_pkg::word_t operand_b;
	logic                 busy;
	logic                 done;      // Last busy cycle, hi and lo valid
	alu_types_pkg::word_t hi;
	alu_types_pkg::word_t lo;

	modport issuer (
		output start, is_signed, operand_a, operand_b,
		input  busy, done, hi, lo
	);

	modport unit (
		input  start, is_signed, operand_a, operand_b,
		output busy, done, hi, lo
	);

	modport monitor (
		input start, is_signed, operand_a, operand_b, busy, done, hi, lo
	);

endinterface

`default_nettype wire

//--- alu_core.sv
// Single-cycle ALU
`timescale 1ns/1ps
`default_nettype none
`include "alu_settings.svh"

module alu_core (
	input  alu_types_pkg::alu_op_e op,
	input  alu_types_pkg::word_t   operand_a,
	input  alu_types_pkg::word_t   operand_b,
	input  alu_types_pkg::word_t   hi_value,
	input  alu_types_pkg::word_t   lo_value,
	output alu_types_pkg::word_t   result
);

	alu_types_pkg::shamt_t shamt;
	alu_types_pkg::word_t  sum;
	alu_types_pkg::word_t  diff;

	// Variable shifts use the same low bits as the fixed ones
	assign shamt = operand_a[$bits(alu_types_pkg::shamt_t)-1:0];

	// Overflow is not trapped, signed and unsigned forms share one adder
	assign sum  = operand_a + operand_b;
	assign diff = operand_a - operand_b;

	always_comb begin
		result = '0; // Long ops, moves to HI/LO and unknown codes
		case (op)
			alu_types_pkg::SLL,
			alu_types_pkg::SLLV: begin
				result = operand_b << shamt;
			end
			alu_types_pkg::SRL,
			alu_types_pkg::SRLV: begin
				result = operand_b >> shamt;
			end
			alu_types_pkg::SRA,
			alu_types_pkg::SRAV: begin
				result = $signed(operand_b) >>> shamt; // Sign fill
			end
			alu_types_pkg::JR,
			alu_types_pkg::JALR,
			alu_types_pkg::PASS_B: begin
				result = operand_b;
			end
			alu_types_pkg::PASS_A: begin
				result = operand_a;
			end
			alu_types_pkg::MFHI: begin
				result = hi_value;
			end
			alu_types_pkg::MFLO: begin
				result = lo_value;
			end
			alu_types_pkg::ADD,
			alu_types_pkg::ADDU: begin
				result = sum;
			end
			alu_types_pkg::SUB,
			alu_types_pkg::SUBU: begin
				result = diff;
			end
			alu_types_pkg::AND: result = operand_a & operand_b;
			alu_types_pkg::OR:  result = operand_a | operand_b;
			alu_types_pkg::XOR: result = operand_a ^ operand_b;
			alu_types_pkg::NOR: result = ~(operand_a | operand_b);
			alu_types_pkg::SLT: begin
				result = {{(`ALU_WIDTH-1){1'b0}}, ($signed(operand_a) < $signed(operand_b))};
			end
			alu_types_pkg::SLTU: begin
				result = {{(`ALU_WIDTH-1){1'b0}}, (operand_a < operand_b)};
			end
			alu_types_pkg::LUI: begin
				result = operand_b << (`ALU_WIDTH / 2); // Immediate into upper half
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- iterative_multiplier.sv
// Shift-add multiplier
`timescale 1ns/1ps
`default_nettype none
`include "alu_settings.svh"

module iterative_multiplier (
	input wire   clk,
	input wire   arst_n,
	muldiv_if.unit bus
);

	localparam int PROD_W = 2 * `ALU_WIDTH;
	localparam int CNT_W  = $clog2(`ALU_MULDIV_CYCLES);
	localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`ALU_MULDIV_CYCLES - 1);

	muldiv_pkg::muldiv_state_e state;
	logic [CNT_W-1:0]          count;
	logic [PROD_W-1:0]         mcand;    // Multiplicand magnitude, moves left each step
	alu_types_pkg::word_t      mplier;   // Multiplier magnitude, moves right each step
	logic [PROD_W-1:0]         acc;
	logic                      negate;   // Product sign
	logic [PROD_W-1:0]         acc_next;
	logic [PROD_W-1:0]         product;

	assign acc_next = mplier[0] ? acc + mcand : acc;
	// Last step is folded in combinationally so done and the result share a cycle
	assign product  = negate ? -acc_next : acc_next;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= muldiv_pkg::IDLE;
			count <= '0;
		end else if (state == muldiv_pkg::IDLE) begin
			if (bus.start) begin
				state <= muldiv_pkg::RUN;
				count <= '0;
			end
		end else begin
			count <= count + 1'b1;
			if (count == LAST_STEP)
				state <= muldiv_pkg::IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (state == muldiv_pkg::IDLE) begin
			acc    <= '0;
			negate <= bus.is_signed && (bus.operand_a[`ALU_WIDTH-1] ^ bus.operand_b[`ALU_WIDTH-1]);
			mcand  <= {{`ALU_WIDTH{1'b0}},
				(bus.is_signed && bus.operand_a[`ALU_WIDTH-1]) ? -bus.operand_a : bus.operand_a};
			mplier <= (bus.is_signed && bus.operand_b[`ALU_WIDTH-1]) ? -bus.operand_b
				: bus.operand_b;
		end else begin
			acc    <= acc_next;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign bus.busy = (state == muldiv_pkg::RUN);
	assign bus.done = (state == muldiv_pkg::RUN) && (count == LAST_STEP);
	assign bus.hi   = product[PROD_W-1:`ALU_WIDTH];
	assign bus.lo   = product[`ALU_WIDTH-1:0];

endmodule

`default_nettype wire

//--- iterative_divider.sv
// Restoring divider
`timescale 1ns/1ps
`default_nettype none
`include "alu_settings.svh"

module iterative_divider (
	input wire   clk,
	input wire   arst_n,
	muldiv_if.unit bus
);

	localparam int CNT_W = $clog2(`ALU_MULDIV_CYCLES);
	localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`ALU_MULDIV_CYCLES - 1);

	muldiv_pkg::muldiv_state_e state;
	logic [CNT_W-1:0]          count;
	alu_types_pkg::word_t      rem;       // Partial remainder
	alu_types_pkg::word_t      quo;       // Dividend bits out, quotient bits in
	alu_types_pkg::word_t      divisor;   // Divisor magnitude
	logic                      neg_quo;
	logic                      neg_rem;   // Remainder follows the dividend sign
	logic                      div_zero;
	logic [`ALU_WIDTH:0]       shifted;
	logic [`ALU_WIDTH:0]       trial;
	logic                      fits;
	alu_types_pkg::word_t      rem_next;
	alu_types_pkg::word_t      quo_next;

	assign shifted  = {rem, quo[`ALU_WIDTH-1]};
	assign trial    = shifted - {1'b0, divisor};
	assign fits     = !trial[`ALU_WIDTH]; // No borrow, keep the subtraction
	assign rem_next = fits ? trial[`ALU_WIDTH-1:0] : shifted[`ALU_WIDTH-1:0];
	assign quo_next = {quo[`ALU_WIDTH-2:0], fits};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= muldiv_pkg::IDLE;
			count <= '0;
		end else if (state == muldiv_pkg::IDLE) begin
			if (bus.start) begin
				state <= muldiv_pkg::RUN;
				count <= '0;
			end
		end else begin
			count <= count + 1'b1;
			if (count == LAST_STEP)
				state <= muldiv_pkg::IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (state == muldiv_pkg::IDLE) begin
			rem      <= '0;
			quo      <= (bus.is_signed && bus.operand_a[`ALU_WIDTH-1]) ? -bus.operand_a
				: bus.operand_a;
			divisor  <= (bus.is_signed && bus.operand_b[`ALU_WIDTH-1]) ? -bus.operand_b
				: bus.operand_b;
			neg_quo  <= bus.is_signed && (bus.operand_a[`ALU_WIDTH-1] ^ bus.operand_b[`ALU_WIDTH-1]);
			neg_rem  <= bus.is_signed && bus.operand_a[`ALU_WIDTH-1];
			div_zero <= (bus.operand_b == '0);
		end else begin
			rem <= rem_next;
			quo <= quo_next;
		end
	end

	assign bus.busy = (state == muldiv_pkg::RUN);
	assign bus.done = (state == muldiv_pkg::RUN) && (count == LAST_STEP);
	// Zero divisor leaves the dividend magnitude as remainder, sign restores it
	assign bus.lo   = div_zero ? '1 : (neg_quo ? -quo_next : quo_next);
	assign bus.hi   = neg_rem ? -rem_next : rem_next;

endmodule

`default_nettype wire

//--- hilo_unit.sv
// HI/LO registers and long-op issue
`timescale 1ns/1ps
`default_nettype none

module hilo_unit (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           issue,
	input  alu_types_pkg::alu_op_e        op,
	input  alu_types_pkg::word_t          operand_a,
	input  alu_types_pkg::word_t          operand_b,
	muldiv_if.issuer                      mul_bus,
	muldiv_if.issuer                      div_bus,
	output alu_types_pkg::word_t          hi,
	output alu_types_pkg::word_t          lo,
	output logic                          stall
);

	logic                  accept;
	logic                  is_move;
	muldiv_pkg::hilo_src_e pend_src; // Unit that was started last
	muldiv_pkg::hilo_src_e wr_src;

	assign stall   = mul_bus.busy | div_bus.busy;
	assign accept  = issue && !stall;
	assign is_move = (op == alu_types_pkg::MTHI) || (op == alu_types_pkg::MTLO);

	assign mul_bus.start     = accept && (op == alu_types_pkg::MULT || op == alu_types_pkg::MULTU);
	assign mul_bus.is_signed = (op == alu_types_pkg::MULT);
	assign mul_bus.operand_a = operand_a;
	assign mul_bus.operand_b = operand_b;
	assign div_bus.start     = accept && (op == alu_types_pkg::DIV || op == alu_types_pkg::DIVU);
	assign div_bus.is_signed = (op == alu_types_pkg::DIV);
	assign div_bus.operand_a = operand_a;
	assign div_bus.operand_b = operand_b;

	// Only the started unit may write, a stray done from the idle unit is dropped
	always_comb begin
		wr_src = muldiv_pkg::NONE;
		if (accept && is_move)
			wr_src = muldiv_pkg::MOVE;
		else if (pend_src == muldiv_pkg::MULT && mul_bus.done)
			wr_src = muldiv_pkg::MULT;
		else if (pend_src == muldiv_pkg::DIV && div_bus.done)
			wr_src = muldiv_pkg::DIV;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_src <= muldiv_pkg::NONE;
			hi       <= '0;
			lo       <= '0;
		end else begin
			if (mul_bus.start)
				pend_src <= muldiv_pkg::MULT;
			else if (div_bus.start)
				pend_src <= muldiv_pkg::DIV;
			else if (wr_src == muldiv_pkg::MULT || wr_src == muldiv_pkg::DIV)
				pend_src <= muldiv_pkg::NONE;

			case (wr_src)
				muldiv_pkg::MULT: begin
					hi <= mul_bus.hi;
					lo <= mul_bus.lo;
				end
				muldiv_pkg::DIV: begin
					hi <= div_bus.hi; // Remainder
					lo <= div_bus.lo; // Quotient
				end
				muldiv_pkg::MOVE: begin
					if (op == alu_types_pkg::MTHI)
						hi <= operand_a;
					else
						lo <= operand_a;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- alu_top.sv
// Execute stage arithmetic top
`timescale 1ns/1ps
`default_nettype none

module alu_top (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    issue,
	input  alu_types_pkg::alu_op_e op,
	input  alu_types_pkg::word_t   operand_a,
	input  alu_types_pkg::word_t   operand_b,
	output alu_types_pkg::word_t   result,
	output alu_types_pkg::word_t   hi,
	output alu_types_pkg::word_t   lo,
	output logic                   stall
);

	muldiv_if mul_bus ();
	muldiv_if div_bus ();

	alu_core u_alu_core (
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.hi_value  (hi),
		.lo_value  (lo),
		.result    (result)
	);

	iterative_multiplier u_multiplier (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (mul_bus.unit)
	);

	iterative_divider u_divider (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (div_bus.unit)
	);

	hilo_unit u_hilo (
		.clk       (clk),
		.arst_n    (arst_n),
		.issue     (issue),
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.mul_bus   (mul_bus.issuer),
		.div_bus   (div_bus.issuer),
		.hi        (hi),
		.lo        (lo),
		.stall     (stall)
	);

endmodule

`default_nettype wire

//--- alu_checker.sv
// ALU result and HI/LO checker
`timescale 1ns/1ps
`default_nettype none
`include "alu_settings.svh"

module alu_checker (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    issue,
	input  alu_types_pkg::alu_op_e op,
	input  alu_types_pkg::word_t   operand_a,
	input  alu_types_pkg::word_t   operand_b,
	input  alu_types_pkg::word_t   result,
	input  alu_types_pkg::word_t   hi,
	input  alu_types_pkg::word_t   lo,
	input  wire                    stall,
	output int                     error_count,
	output int                     check_count
);

	alu_types_pkg::word_t  exp_hi;
	alu_types_pkg::word_t  exp_lo;
	logic [63:0]           ref_pair;
	logic [63:0]           pend_pair;  // HI/LO pair of the long op in flight
	int                    remaining;  // Stall cycles still expected
	muldiv_pkg::hilo_src_e pend_src;
	muldiv_pkg::hilo_src_e writer;     // Last writer of HI/LO in the model

	function automatic logic is_long(alu_types_pkg::alu_op_e op_v);
		return op_v inside {alu_types_pkg::MULT, alu_types_pkg::MULTU,
			alu_types_pkg::DIV, alu_types_pkg::DIVU};
	endfunction

	// Single-cycle ops give {0, result}, long ops give {hi, lo}
	function automatic logic [63:0] reference_model(alu_types_pkg::alu_op_e op_v,
		alu_types_pkg::word_t a, alu_types_pkg::word_t b,
		alu_types_pkg::word_t hi_v, alu_types_pkg::word_t lo_v);
		logic [63:0]          wide_a;
		logic [63:0]          wide_b;
		logic [63:0]          sra_wide;
		logic [4:0]           sh;
		logic                 signed_op;
		alu_types_pkg::word_t mag_a;
		alu_types_pkg::word_t mag_b;
		alu_types_pkg::word_t quo;
		alu_types_pkg::word_t rem;
		sh = a[4:0];
		signed_op = (op_v == alu_types_pkg::MULT) || (op_v == alu_types_pkg::DIV);
		reference_model = '0;
		case (op_v)
			alu_types_pkg::SLL, alu_types_pkg::SLLV: reference_model[31:0] = b << sh;
			alu_types_pkg::SRL, alu_types_pkg::SRLV: reference_model[31:0] = b >> sh;
			alu_types_pkg::SRA, alu_types_pkg::SRAV: begin
				sra_wide = {{32{b[31]}}, b} >> sh; // Sign bits shift in from above
				reference_model[31:0] = sra_wide[31:0];
			end
			alu_types_pkg::JR, alu_types_pkg::JALR, alu_types_pkg::PASS_B: begin
				reference_model[31:0] = b;
			end
			alu_types_pkg::PASS_A: reference_model[31:0] = a;
			alu_types_pkg::MFHI: reference_model[31:0] = hi_v;
			alu_types_pkg::MFLO: reference_model[31:0] = lo_v;
			alu_types_pkg::ADD, alu_types_pkg::ADDU: reference_model[31:0] = a + b;
			alu_types_pkg::SUB, alu_types_pkg::SUBU: reference_model[31:0] = a - b;
			alu_types_pkg::AND: reference_model[31:0] = a & b;
			alu_types_pkg::OR:  reference_model[31:0] = a | b;
			alu_types_pkg::XOR: reference_model[31:0] = a ^ b;
			alu_types_pkg::NOR: reference_model[31:0] = ~(a | b);
			alu_types_pkg::SLT: reference_model[0] = (a[31] != b[31]) ? a[31] : (a < b);
			alu_types_pkg::SLTU: reference_model[0] = (a < b);
			alu_types_pkg::LUI: reference_model[31:0] = {b[15:0], 16'h0000};
			alu_types_pkg::MULT, alu_types_pkg::MULTU: begin
				wide_a = signed_op ? {{32{a[31]}}, a} : {32'h0, a};
				wide_b = signed_op ? {{32{b[31]}}, b} : {32'h0, b};
				reference_model = wide_a * wide_b; // Low 64 bits are exact either way
			end
			alu_types_pkg::DIV, alu_types_pkg::DIVU: begin
				if (b == '0) begin
					reference_model = {a, 32'hffff_ffff};
				end else begin
					mag_a = (signed_op && a[31]) ? -a : a;
					mag_b = (signed_op && b[31]) ? -b : b;
					quo = mag_a / mag_b;
					rem = mag_a % mag_b;
					if (signed_op && (a[31] ^ b[31]))
						quo = -quo; // Truncation toward zero
					if (signed_op && a[31])
						rem = -rem;
					reference_model = {rem, quo};
				end
			end
			default: reference_model = '0;
		endcase
	endfunction

	task automatic compare_word(input string what, input alu_types_pkg::word_t got,
		input alu_types_pkg::word_t want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_hi    = '0;
			exp_lo    = '0;
			pend_pair = '0;
			remaining = 0;
			pend_src  = muldiv_pkg::NONE;
			writer    = muldiv_pkg::NONE;
		end else begin
			// Values sampled here are the ones from before this edge
			ref_pair = reference_model(op, operand_a, operand_b, exp_hi, exp_lo);
			compare_word($sformatf("hi (last writer %s)", writer.name()), hi, exp_hi);
			compare_word($sformatf("lo (last writer %s)", writer.name()), lo, exp_lo);
			compare_word("stall", alu_types_pkg::word_t'(stall),
				alu_types_pkg::word_t'(remaining != 0));
			if (issue && !stall)
				compare_word($sformatf("result of %s", op.name()), result,
					is_long(op) ? '0 : ref_pair[31:0]);

			if (remaining != 0) begin
				remaining--;
				if (remaining == 0) begin // Edge where stall falls
					exp_hi = pend_pair[63:32];
					exp_lo = pend_pair[31:0];
					writer = pend_src;
				end
			end else if (issue && !stall) begin
				if (op == alu_types_pkg::MTHI) begin
					exp_hi = operand_a;
					writer = muldiv_pkg::MOVE;
				end else if (op == alu_types_pkg::MTLO) begin
					exp_lo = operand_a;
					writer = muldiv_pkg::MOVE;
				end else if (is_long(op)) begin
					pend_pair = ref_pair;
					remaining = `ALU_MULDIV_CYCLES;
					pend_src  = (op == alu_types_pkg::MULT || op == alu_types_pkg::MULTU) ?
						muldiv_pkg::MULT : muldiv_pkg::DIV;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_alu.sv
// ALU execute stage testbench
`timescale 1ns/1ps
`default_nettype none
`include "alu_settings.svh"

module tb_alu;

	localparam int RANDOM_OPS  = 300;
	localparam int CYCLE_LIMIT = RANDOM_OPS * (`ALU_MULDIV_CYCLES + 4) + 500;
	localparam int EDGE_PAIRS  = 8;

	// Corner operand pairs, every opcode runs over each of them
	localparam alu_types_pkg::word_t EDGE_A [EDGE_PAIRS] = '{
		32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_001f,
		32'hffff_fff9, 32'h8000_0000, 32'h1234_5678, 32'h0000_0007};
	localparam alu_types_pkg::word_t EDGE_B [EDGE_PAIRS] = '{
		32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0001,
		32'h0000_0002, 32'hffff_ffff, 32'h0000_0000, 32'hffff_fffe};

	logic                   clk;
	logic                   arst_n;
	logic                   issue;
	alu_types_pkg::alu_op_e op;
	alu_types_pkg::word_t   operand_a;
	alu_types_pkg::word_t   operand_b;
	alu_types_pkg::word_t   result;
	alu_types_pkg::word_t   hi;
	alu_types_pkg::word_t   lo;
	logic                   stall;
	int                     error_count;
	int                     check_count;
	int                     cycle_count = 0;

	alu_top DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.issue     (issue),
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.result    (result),
		.hi        (hi),
		.lo        (lo),
		.stall     (stall)
	);

	alu_checker u_checker (
		.clk         (clk),
		.arst_n      (arst_n),
		.issue       (issue),
		.op          (op),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.result      (result),
		.hi          (hi),
		.lo          (lo),
		.stall       (stall),
		.error_count (error_count),
		.check_count (check_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout reached after %0d cycles, test sequence did not finish",
				cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic next_drive_point();
		@(posedge clk);
		#2;
	endtask

	// Waits out any stall, then holds issue for one cycle
	task automatic issue_op(input alu_types_pkg::alu_op_e op_v, input alu_types_pkg::word_t a,
		input alu_types_pkg::word_t b);
		while (stall)
			next_drive_point();
		issue     = 1'b1;
		op        = op_v;
		operand_a = a;
		operand_b = b;
		next_drive_point();
		issue = 1'b0;
	endtask

	function automatic alu_types_pkg::alu_op_e op_at(int k);
		alu_types_pkg::alu_op_e v;
		v = v.first();
		repeat (k)
			v = v.next();
		return v;
	endfunction

	function automatic alu_types_pkg::word_t pick_operand();
		case ($urandom % 8)
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000; // Most negative
			3: return 32'h7fff_ffff;
			4: return 32'h0000_001f; // Largest shift
			default: return $urandom;
		endcase
	endfunction

	initial begin
		alu_types_pkg::alu_op_e probe;
		issue     = 1'b0;
		op        = alu_types_pkg::PASS_A;
		operand_a = '0;
		operand_b = '0;
		arst_n    = 1'b0;
		void'($urandom(88446));
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;
		next_drive_point();

		issue_op(alu_types_pkg::MFHI, '0, '0); // Zero straight out of reset
		issue_op(alu_types_pkg::MFLO, '0, '0);
		issue_op(alu_types_pkg::MTHI, 32'h1357_9bdf, '0);
		issue_op(alu_types_pkg::MTLO, 32'h2468_ace0, '0);
		issue_op(alu_types_pkg::MFHI, '0, '0);
		issue_op(alu_types_pkg::MFLO, '0, '0);

		for (int p = 0; p < EDGE_PAIRS; p++)
			for (int k = 0; k < probe.num(); k++)
				issue_op(op_at(k), EDGE_A[p], EDGE_B[p]);

		// Multiply and divide back to back, alternating
		for (int k = 0; k < 4; k++) begin
			issue_op(alu_types_pkg::MULT, $urandom, $urandom);
			issue_op(alu_types_pkg::DIV, $urandom, $urandom);
			issue_op(alu_types_pkg::MULTU, $urandom, $urandom);
			issue_op(alu_types_pkg::DIVU, $urandom, $urandom >> (k * 8));
		end
		issue_op(alu_types_pkg::MFHI, '0, '0);
		issue_op(alu_types_pkg::MFLO, '0, '0);

		repeat (RANDOM_OPS)
			issue_op(op_at($urandom % probe.num()), pick_operand(), pick_operand());

		while (stall)
			next_drive_point();
		repeat (2) next_drive_point(); // Last HI/LO update gets checked

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
alu_types_pkg.sv
muldiv_pkg.sv
muldiv_if.sv
alu_core.sv
iterative_multiplier.sv
iterative_divider.sv
hilo_unit.sv
alu_top.sv
alu_checker.sv
tb_alu.sv

//--- Makefile
.PHONY: all lint clean

all: obj_dir/Vtb_alu
	@out="$$(./obj_dir/Vtb_alu)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

obj_dir/Vtb_alu: src.f $(wildcard *.sv *.svh)
	verilator --binary --timing -f src.f --top-module tb_alu

lint:
	verilator --lint-only --timing -f src.f --top-module tb_alu

clean:
	rm -rf obj_dir
